//--- run.sh
#!/usr/bin/env bash
# Build and run the testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal -f sim.f \
    --top-module agu_tb --Mdir obj_dir -o agu_sim; then
  echo "build failed"
  exit 1
fi

./obj_dir/agu_sim > "$LOG" 2>&1
status=$?
cat "$LOG"

if grep -q "Verification failed" "$LOG"; then
  echo "simulation reported failure"
  exit 1
fi
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi
if ! grep -q "Verification passed" "$LOG"; then
  echo "no result line in $LOG"
  exit 1
fi
exit 0

//--- sim.f
+incdir+src
src/agu_pkg.sv
src/addr_gen.sv
src/addr_fifo.sv
src/mem_reader.sv
src/agu_top.sv
sim/clk_gen.sv
sim/agu_asserts.sv
sim/agu_tb.sv

//--- sim/agu_asserts.sv
`default_nettype none

`include "agu_consts.svh"

module agu_asserts import agu_pkg::*; (
  input wire        clk_i,
  input wire        rst_i,
  input wire        run_i,
  input wire        addr_valid_i,
  input wire        addr_ready_i,
  input wire addr_t addr_i,
  input wire        fifo_push_i,
  input wire        fifo_full_i,
  input wire        fifo_pop_i,
  input wire        fifo_empty_i,
  input wire        data_valid_i,
  input wire        data_ready_i,
  input wire data_t data_i,
  input wire        done_i
);

  localparam int OCC_W = $clog2(`AGU_FIFO_DEPTH) + 1;

  logic [OCC_W-1:0] occupancy;  // buffer entries seen from the handshakes.

  //////////////////////////////
  // buffer occupancy
  //////////////////////////////

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      occupancy <= '0;
    end else if (run_i) begin
      occupancy <= '0;  // flushed with the job start.
    end else if (fifo_push_i && !fifo_pop_i) begin
      occupancy <= occupancy + 1'b1;
    end else if (fifo_pop_i && !fifo_push_i) begin
      occupancy <= occupancy - 1'b1;
    end
  end

  // generator holds its address until the buffer takes it.
  addr_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    addr_valid_i && !addr_ready_i && !run_i |=> $stable(addr_i))
    else $error("address changed while waiting for the buffer");

  buffer_flags: assert property (@(posedge clk_i) disable iff (rst_i)
    (fifo_full_i == (occupancy == OCC_W'(`AGU_FIFO_DEPTH)))
    && (fifo_empty_i == (occupancy == '0)))
    else $error("buffer flags disagree with the number of entries held");

  no_push_full: assert property (@(posedge clk_i) disable iff (rst_i)
    !(fifo_push_i && occupancy == OCC_W'(`AGU_FIFO_DEPTH)))
    else $error("buffer pushed while full");

  no_pop_empty: assert property (@(posedge clk_i) disable iff (rst_i)
    !(fifo_pop_i && occupancy == '0))
    else $error("buffer popped while empty");

  data_hold: assert property (@(posedge clk_i) disable iff (rst_i)
    data_valid_i && !data_ready_i && !run_i |=> data_valid_i && $stable(data_i))
    else $error("output word changed under stall");

  // nothing may be left anywhere in the path once done is high.
  no_done_pending: assert property (@(posedge clk_i) disable iff (rst_i)
    done_i |-> !data_valid_i && !addr_valid_i && occupancy == '0)
    else $error("done high while work is pending");

endmodule

bind agu_top agu_asserts u_asserts (
  .clk_i        (clk_i),
  .rst_i        (rst_i),
  .run_i        (run_i),
  .addr_valid_i (addr_valid),
  .addr_ready_i (addr_ready),
  .addr_i       (addr),
  .fifo_push_i  (fifo_push),
  .fifo_full_i  (fifo_full),
  .fifo_pop_i   (fifo_pop),
  .fifo_empty_i (fifo_empty),
  .data_valid_i (data_valid_o),
  .data_ready_i (data_ready_i),
  .data_i       (data_o),
  .done_i       (done_o)
);

`default_nettype wire

//--- sim/agu_tb.sv
`default_nettype none

`include "agu_consts.svh"

module agu_tb import agu_pkg::*; ();

  localparam int CLK_PERIOD = 4;
  localparam int WORDS      = 1 << (`AGU_ADDR_W - `AGU_OFFSET_W);
  localparam int ADDR_MASK  = (1 << `AGU_ADDR_W) - 1;
  localparam int BYTES      = 1 << `AGU_OFFSET_W;
  localparam int N_RANDOM   = 20;
  localparam int N_JOBS     = N_RANDOM + 2;
  localparam int MAX_DELAY  = 32;
  localparam int MAX_LEN    = 72;   // 8 iterations of up to 9 steps.
  localparam int MARGIN     = 300;  // preload and rewrites.
  localparam int WATCHDOG_CYCLES = N_JOBS * (MAX_DELAY + MAX_LEN * 4 + MARGIN);

  logic      clk;
  logic      rst;
  logic      run;
  addr_t     iterations;
  period_t   period;
  period_t   duty;
  delay_t    delay;
  addr_t     start;
  addr_t     shift;
  addr_t     incr;
  logic      mem_we;
  word_idx_t mem_waddr;
  data_t     mem_wdata;
  logic      data_valid;
  data_t     data;
  logic      data_ready;
  logic      done;

  integer seed;
  int     error_count;
  bit     fail_printed;
  bit     passed;
  data_t  mem_model [WORDS];
  data_t  exp_q [$];

  clk_gen u_clk (.clk_o(clk));

  agu_top dut (
    .clk_i        (clk),
    .rst_i        (rst),
    .run_i        (run),
    .iterations_i (iterations),
    .period_i     (period),
    .duty_i       (duty),
    .delay_i      (delay),
    .start_i      (start),
    .shift_i      (shift),
    .incr_i       (incr),
    .mem_we_i     (mem_we),
    .mem_waddr_i  (mem_waddr),
    .mem_wdata_i  (mem_wdata),
    .data_valid_o (data_valid),
    .data_o       (data),
    .data_ready_i (data_ready),
    .done_o       (done)
  );

  //////////////////////////////
  // checks
  //////////////////////////////

  task automatic report_failure(string msg);
    error_count++;
    $display("%s", msg);
    $display("Verification failed");
    fail_printed = 1'b1;
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check_data(string name, data_t expected, data_t actual);
    if (actual !== expected) begin
      report_failure($sformatf("error: %s: expected %h, actual %h", name, expected, actual));
    end
  endtask

  task automatic check_done(string name, logic expected, logic actual);
    if (actual !== expected) begin
      report_failure($sformatf("error: %s: expected done %b, actual %b", name, expected, actual));
    end
  endtask

  //////////////////////////////
  // memory load
  //////////////////////////////

  task automatic write_word(word_idx_t idx, data_t value);
    mem_we    = 1'b1;
    mem_waddr = idx;
    mem_wdata = value;
    mem_model[idx] = value;
    @(posedge clk);
    #1;
    mem_we = 1'b0;
  endtask

  task automatic preload_memory();
    for (int i = 0; i < WORDS; i++) begin
      write_word(word_idx_t'(i), data_t'($random(seed)));
    end
  endtask

  task automatic rewrite_words(int count);
    for (int i = 0; i < count; i++) begin
      write_word(word_idx_t'($random(seed)), data_t'($random(seed)));
    end
  endtask

  //////////////////////////////
  // model and jobs
  //////////////////////////////

  // walks the addressing rule in byte units, wrapping at the address width.
  task automatic build_expected();
    int cur;
    cur = int'(start);
    exp_q.delete();
    for (int i = 0; i < int'(iterations); i++) begin
      for (int p = 0; p < int'(period); p++) begin
        exp_q.push_back(mem_model[(cur & ADDR_MASK) / BYTES]);
        if (p == int'(period) - 1) begin
          cur = cur + BYTES * int'($signed(shift));
        end else if (p < int'(duty)) begin
          cur = cur + BYTES * int'($signed(incr));
        end
      end
    end
  endtask

  task automatic randomize_job();
    iterations = addr_t'(1 + ($random(seed) & 7));
    period     = period_t'(2 + ($random(seed) & 7));
    duty       = period_t'(($random(seed) & 15) % int'(period));  // below period.
    delay      = delay_t'(1 + ($random(seed) & 31));
    start      = addr_t'($random(seed));
    shift      = addr_t'($random(seed) % 8);  // signed, -7 to 7.
    incr       = addr_t'($random(seed) % 8);
  endtask

  // starts and ends 1 unit after a rising edge.
  task automatic run_job(string name, bit stall);
    int got;
    int n;
    bit drained;
    build_expected();
    n = exp_q.size();
    got = 0;
    drained = 1'b0;
    run = 1'b1;
    @(posedge clk);
    #1;
    run = 1'b0;
    while (!drained) begin
      data_ready = stall ? (($random(seed) & 3) != 0) : 1'b1;
      @(negedge clk);
      check_done(name, got == n, done);  // high exactly once every word is taken.
      if (got == n) begin
        drained = 1'b1;
      end else if (data_valid && data_ready) begin
        check_data($sformatf("%s word %0d", name, got), exp_q[got], data);
        got++;
      end
      @(posedge clk);
      #1;
    end
    repeat (8) begin
      data_ready = ($random(seed) & 1) != 0;
      @(negedge clk);
      if (data_valid) begin
        report_failure($sformatf("%s: a word appeared after done_o rose", name));
      end
      check_done(name, 1'b1, done);
      @(posedge clk);
      #1;
    end
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    seed         = 32'h2b87_0af3;
    error_count  = 0;
    fail_printed = 1'b0;
    passed       = 1'b0;
    rst          = 1'b1;
    run          = 1'b0;
    iterations   = '0;
    period       = '0;
    duty         = '0;
    delay        = '0;
    start        = '0;
    shift        = '0;
    incr         = '0;
    mem_we       = 1'b0;
    mem_waddr    = '0;
    mem_wdata    = '0;
    data_ready   = 1'b0;
    repeat (10) @(posedge clk);
    #1;
    rst = 1'b0;
    @(negedge clk);
    check_done("reset", 1'b1, done);
    if (data_valid) begin
      report_failure("data_valid_o is high after reset");
    end
    @(posedge clk);
    #1;
    preload_memory();

    // plain linear walk, then the same job over new memory contents.
    iterations = addr_t'(6);
    period     = period_t'(4);
    duty       = period_t'(4);
    delay      = '0;
    start      = addr_t'('h040);
    shift      = addr_t'(1);
    incr       = addr_t'(1);
    run_job("linear", 1'b0);
    preload_memory();
    run_job("rewrite", 1'b1);

    for (int j = 0; j < N_RANDOM; j++) begin
      rewrite_words(16);
      randomize_job();
      run_job($sformatf("random_%0d", j), j[0]);  // odd jobs see back-pressure.
    end

    if (error_count == 0) begin
      passed = 1'b1;
      $display("Verification passed");
    end else begin
      fail_printed = 1'b1;
      $display("Verification failed");
    end
    $finish;
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    report_failure("watchdog timeout, the jobs did not finish in time");
  end

  // a run cut short by a failed assertion.
  final begin
    if (!passed && !fail_printed) begin
      $display("Verification failed");
    end
  end

endmodule

`default_nettype wire

//--- sim/clk_gen.sv
`default_nettype none

module clk_gen (
  output logic clk_o
);

  localparam int HALF_PERIOD = 2;  // period of 4.

  initial begin
    clk_o = 1'b0;
    forever #HALF_PERIOD clk_o = ~clk_o;
  end

endmodule

`default_nettype wire

//--- src/addr_fifo.sv
`default_nettype none

`include "agu_consts.svh"

module addr_fifo import agu_pkg::*; (
  input  wire        clk_i,
  input  wire        rst_i,
  input  wire        flush_i,

  // write side.
  input  wire        push_i,
  input  wire addr_t push_addr_i,
  output logic       full_o,

  // read side.
  input  wire        pop_i,
  output logic       empty_o,
  output addr_t      head_o
);

  localparam int PTR_W = $clog2(`AGU_FIFO_DEPTH);

  addr_t            mem [`AGU_FIFO_DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [PTR_W:0]   count;

  assign full_o  = count == (PTR_W + 1)'(`AGU_FIFO_DEPTH);
  assign empty_o = count == '0;
  assign head_o  = mem[rd_ptr];  // valid only while not empty.

  //////////////////////////////
  // pointers and occupancy
  //////////////////////////////

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else if (flush_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_i) begin
        wr_ptr <= wr_ptr + 1'b1;  // wraps, depth is a power of two.
      end
      if (pop_i) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push_i && !pop_i) begin
        count <= count + 1'b1;
      end else if (pop_i && !push_i) begin
        count <= count - 1'b1;
      end
    end
  end

  //////////////////////////////
  // storage
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem[wr_ptr] <= push_addr_i;
    end
  end

endmodule

`default_nettype wire

//--- src/addr_gen.sv
`default_nettype none

`include "agu_consts.svh"

module addr_gen import agu_pkg::*; (
  input  wire        clk_i,
  input  wire        rst_i,

  input  wire        run_i,

  // job configuration, stable during a job.
  input  wire addr_t   iterations_i,
  input  wire period_t period_i,
  input  wire period_t duty_i,
  input  wire delay_t  delay_i,
  input  wire addr_t   start_i,
  input  wire addr_t   shift_i,  // signed.
  input  wire addr_t   incr_i,   // signed.

  output logic       valid_o,
  input  wire        ready_i,
  output addr_t      addr_o,

  output logic       done_o
);

  gen_state_t state;
  delay_t     delay_cnt;
  period_t    per;
  addr_t      iter;
  addr_t      incr_step;
  addr_t      shift_step;
  logic       per_last;
  logic       iter_last;
  logic       accept;

  // scaled to bytes, two's complement wraps modulo the address width.
  assign incr_step  = incr_i << `AGU_OFFSET_W;
  assign shift_step = shift_i << `AGU_OFFSET_W;

  // one bit wider so a full counter does not wrap in the compare.
  assign per_last  = ({1'b0, per} + 1'b1) >= {1'b0, period_i};
  assign iter_last = ({1'b0, iter} + 1'b1) >= {1'b0, iterations_i};

  assign accept = valid_o && ready_i;

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      state     <= GEN_IDLE;
      delay_cnt <= '0;
      per       <= '0;
      iter      <= '0;
      addr_o    <= '0;
      valid_o   <= 1'b0;
      done_o    <= 1'b1;
    end else if (run_i) begin
      delay_cnt <= delay_i;
      addr_o    <= start_i;
      per       <= '0;
      iter      <= '0;
      done_o    <= 1'b0;
      if (delay_i == '0) begin
        state   <= GEN_STREAM;
        valid_o <= 1'b1;
      end else begin
        state   <= GEN_DELAY;
        valid_o <= 1'b0;
      end
    end else begin
      case (state)
        GEN_DELAY: begin
          if (delay_cnt == delay_t'(1)) begin  // first address after delay + 1 cycles.
            state   <= GEN_STREAM;
            valid_o <= 1'b1;
          end
          delay_cnt <= delay_cnt - 1'b1;
        end
        GEN_STREAM: begin
          if (accept) begin
            if (per_last && iter_last) begin
              state   <= GEN_IDLE;
              valid_o <= 1'b0;
              done_o  <= 1'b1;
            end else if (per_last) begin
              // end of iteration.
              addr_o <= addr_o + shift_step;
              per    <= '0;
              iter   <= iter + 1'b1;
            end else begin
              if (per < duty_i) begin
                addr_o <= addr_o + incr_step;
              end
              per <= per + 1'b1;
            end
          end
        end
        default: state <= GEN_IDLE;
      endcase
    end
  end

endmodule

`default_nettype wire

//--- src/agu_consts.svh
`ifndef AGU_CONSTS_SVH
`define AGU_CONSTS_SVH

//////////////////////////////
// address and counter widths
//////////////////////////////

`define AGU_ADDR_W     10  // byte address.
`define AGU_PERIOD_W   10  // period and duty counters.
`define AGU_DELAY_W    16  // start delay counter.

//////////////////////////////
// data path
//////////////////////////////

`define AGU_DATA_W     32
`define AGU_OFFSET_W   2   // log2 of bytes per word.

// address buffer entries, power of two.
`define AGU_FIFO_DEPTH 4

`endif

//--- src/agu_pkg.sv
`default_nettype none

`include "agu_consts.svh"

package agu_pkg;

  //////////////////////////////
  // vector types
  //////////////////////////////

  typedef logic [`AGU_ADDR_W-1:0]   addr_t;   // byte address.
  typedef logic [`AGU_PERIOD_W-1:0] period_t;
  typedef logic [`AGU_DELAY_W-1:0]  delay_t;
  typedef logic [`AGU_DATA_W-1:0]   data_t;

  // byte address with the offset dropped.
  typedef logic [`AGU_ADDR_W-`AGU_OFFSET_W-1:0] word_idx_t;

  //////////////////////////////
  // generator fsm
  //////////////////////////////

  typedef enum logic [1:0] {
    GEN_IDLE,
    GEN_DELAY,
    GEN_STREAM
  } gen_state_t;

endpackage

`default_nettype wire

//--- src/agu_top.sv
`default_nettype none

module agu_top import agu_pkg::*; (
  input  wire            clk_i,
  input  wire            rst_i,

  input  wire            run_i,

  // job configuration.
  input  wire addr_t     iterations_i,
  input  wire period_t   period_i,
  input  wire period_t   duty_i,
  input  wire delay_t    delay_i,
  input  wire addr_t     start_i,
  input  wire addr_t     shift_i,
  input  wire addr_t     incr_i,

  // memory load.
  input  wire            mem_we_i,
  input  wire word_idx_t mem_waddr_i,
  input  wire data_t     mem_wdata_i,

  output logic           data_valid_o,
  output data_t          data_o,
  input  wire            data_ready_i,

  output logic           done_o
);

  logic  addr_valid;
  logic  addr_ready;
  addr_t addr;
  logic  gen_done;
  logic  fifo_push;
  logic  fifo_full;
  logic  fifo_pop;
  logic  fifo_empty;
  addr_t fifo_head;

  assign addr_ready = !fifo_full;
  assign fifo_push  = addr_valid && addr_ready;  // handshake.

  addr_gen u_gen (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .run_i        (run_i),
    .iterations_i (iterations_i),
    .period_i     (period_i),
    .duty_i       (duty_i),
    .delay_i      (delay_i),
    .start_i      (start_i),
    .shift_i      (shift_i),
    .incr_i       (incr_i),
    .valid_o      (addr_valid),
    .ready_i      (addr_ready),
    .addr_o       (addr),
    .done_o       (gen_done)
  );

  // run_i restarts the whole path.
  addr_fifo u_fifo (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .flush_i     (run_i),
    .push_i      (fifo_push),
    .push_addr_i (addr),
    .full_o      (fifo_full),
    .pop_i       (fifo_pop),
    .empty_o     (fifo_empty),
    .head_o      (fifo_head)
  );

  mem_reader u_reader (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .flush_i      (run_i),
    .we_i         (mem_we_i),
    .waddr_i      (mem_waddr_i),
    .wdata_i      (mem_wdata_i),
    .empty_i      (fifo_empty),
    .head_i       (fifo_head),
    .pop_o        (fifo_pop),
    .gen_done_i   (gen_done),
    .data_valid_o (data_valid_o),
    .data_o       (data_o),
    .data_ready_i (data_ready_i),
    .done_o       (done_o)
  );

endmodule

`default_nettype wire

//--- src/mem_reader.sv
`default_nettype none

`include "agu_consts.svh"

module mem_reader import agu_pkg::*; (
  input  wire            clk_i,
  input  wire            rst_i,
  input  wire            flush_i,

  // memory load port.
  input  wire            we_i,
  input  wire word_idx_t waddr_i,
  input  wire data_t     wdata_i,

  // address buffer head.
  input  wire            empty_i,
  input  wire addr_t     head_i,
  output logic           pop_o,

  input  wire            gen_done_i,

  // word stream out.
  output logic           data_valid_o,
  output data_t          data_o,
  input  wire            data_ready_i,

  output logic           done_o
);

  localparam int WORDS = 1 << (`AGU_ADDR_W - `AGU_OFFSET_W);

  data_t     mem [WORDS];
  word_idx_t rd_idx;

  assign rd_idx = head_i[`AGU_ADDR_W-1:`AGU_OFFSET_W];  // drop byte offset.

  // pop when the output register is free or being taken.
  assign pop_o = !flush_i && !empty_i && (!data_valid_o || data_ready_i);

  // job drained, nothing buffered and nothing pending.
  assign done_o = gen_done_i && empty_i && !data_valid_o;

  //////////////////////////////
  // output register
  //////////////////////////////

  always_ff @(posedge clk_i or posedge rst_i) begin
    if (rst_i) begin
      data_valid_o <= 1'b0;
    end else if (flush_i) begin
      data_valid_o <= 1'b0;
    end else if (pop_o) begin
      data_valid_o <= 1'b1;
    end else if (data_ready_i) begin
      data_valid_o <= 1'b0;
    end
  end

  //////////////////////////////
  // word memory
  //////////////////////////////

  always_ff @(posedge clk_i) begin
    if (we_i) begin
      mem[waddr_i] <= wdata_i;
    end
    if (pop_o) begin
      data_o <= mem[rd_idx];  // old word on a same-cycle write.
    end
  end

endmodule

`default_nettype wire
